// ==== run.sh ====
#!/bin/sh
# Compile and run the response park testbench with Verilator
# The result comes from the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found on PATH"
  exit 1
fi

verilator --binary --timing --assert \
  --top-module response_park_tb \
  -Mdir obj_dir \
  -f sources.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

sim_out=$(./obj_dir/Vresponse_park_tb 2>&1)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1

// ==== source/occupancy_tracker.sv ====
// ----------------------------------------
// Occupancy counter with headroom full
// ----------------------------------------

`timescale 1ns/1ps

module occupancy_tracker (
  input  logic clk,
  input  logic rst,
  input  logic enq_accept,
  input  logic free_accept,
  output logic full
);

  import response_park_pkg::*;

  // Parked responses right now
  count_t count_q;

  // ----------------------------------------
  // Counter
  // ----------------------------------------

  // Up on enqueue, down on free, hold when both land together
  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else begin
      case ({enq_accept, free_accept})
        2'b10:   count_q <= count_q + count_t'(1);
        2'b01:   count_q <= count_q - count_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Full at depth minus headroom
  // Comes straight off the register, so one cycle after the event
  assign full = (count_q == park_full_level);

  // ----------------------------------------
  // Assertions
  // ----------------------------------------

  // Enqueue gating in the slot table keeps the count at or below the limit
  assert property (@(posedge clk) disable iff (rst)
    count_q <= park_full_level)
    else $error("occupancy_tracker: count %0d above full level", count_q);

  // A lone free needs something parked
  assert property (@(posedge clk) disable iff (rst)
    (free_accept && !enq_accept) |-> (count_q != '0))
    else $error("occupancy_tracker: decrement from zero");

endmodule

// ==== source/response_park.sv ====
// ----------------------------------------
// Response park top level
// Slot table plus occupancy tracker
// ----------------------------------------

`timescale 1ns/1ps

module response_park (
  input  logic                          clk,
  input  logic                          rst,
  // Enqueue from the fabric R channel, tagged by UID
  input  logic                          in_valid,
  input  response_park_pkg::uid_t       in_uid,
  input  response_park_pkg::park_resp_t in_payload,
  output logic                          in_ready,
  // Allocate from the ordering arbiter
  input  logic                          alloc_req,
  input  response_park_pkg::uid_t       alloc_uid,
  output logic                          alloc_gnt,
  output response_park_pkg::park_resp_t out_payload,
  // Free from the consumer
  input  logic                          free_req,
  input  response_park_pkg::uid_t       free_uid,
  output logic                          free_ack,
  // Headroom full flag
  output logic                          full
);

  // ----------------------------------------
  // Internal events
  // ----------------------------------------

  // Accepted enqueue, one pulse per beat
  logic enq_accept;

  // Accepted free of an occupied slot
  logic free_accept;

  // Flags, payloads and request resolution
  slot_table u_slot_table (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_uid      (in_uid),
    .in_payload  (in_payload),
    .in_ready    (in_ready),
    .full        (full),
    .alloc_req   (alloc_req),
    .alloc_uid   (alloc_uid),
    .alloc_gnt   (alloc_gnt),
    .out_payload (out_payload),
    .free_req    (free_req),
    .free_uid    (free_uid),
    .free_ack    (free_ack),
    .enq_accept  (enq_accept),
    .free_accept (free_accept)
  );

  // Count of parked responses
  // full feeds the slot table and the port
  occupancy_tracker u_occupancy_tracker (
    .clk         (clk),
    .rst         (rst),
    .enq_accept  (enq_accept),
    .free_accept (free_accept),
    .full        (full)
  );

endmodule

// ==== source/response_park_defines.svh ====
// ----------------------------------------
// Size macros for the response park
// Depth, headroom and payload field widths
// ----------------------------------------

`ifndef RESPONSE_PARK_DEFINES_SVH
`define RESPONSE_PARK_DEFINES_SVH

// Number of UID slots
// Also sets the UID width
`define PARK_DEPTH 16

// Slots that are never filled
// Leave-one-free policy against fabric deadlock
`define PARK_HEADROOM 1

// Read data width
// Cut down from the 256-bit bus for simulation
`define PARK_DATA_W 64

// AXI read response code width
`define PARK_RESP_W 2

// Master-facing original ID width
`define PARK_OID_W 8

`endif

// ==== source/response_park_pkg.sv ====
// ----------------------------------------
// Types shared by the response park
// Vector typedefs and the parked struct
// ----------------------------------------

`include "response_park_defines.svh"

package response_park_pkg;

  // Internal UID, also the slot index
  typedef logic [$clog2(`PARK_DEPTH)-1:0] uid_t;

  // Read data beat
  typedef logic [`PARK_DATA_W-1:0] data_t;

  // AXI response code
  typedef logic [`PARK_RESP_W-1:0] resp_t;

  // Original ID as the master issued it
  typedef logic [`PARK_OID_W-1:0] oid_t;

  // Occupancy count
  // One bit wider than the UID so the full depth fits
  typedef logic [$clog2(`PARK_DEPTH):0] count_t;

  // One whole parked response
  // Original ID on top, data in the low bits
  typedef struct packed {
    oid_t  oid;
    resp_t resp;
    data_t data;
  } park_resp_t;

  // Count at which enqueues stop
  localparam count_t park_full_level = count_t'(`PARK_DEPTH - `PARK_HEADROOM);

endpackage

// ==== source/slot_table.sv ====
// ----------------------------------------
// Per-UID slot flags and payload storage
// Enqueue, allocate and free control
// ----------------------------------------

`timescale 1ns/1ps

`include "response_park_defines.svh"

module slot_table (
  input  logic                         clk,
  input  logic                         rst,
  // Enqueue plane
  input  logic                         in_valid,
  input  response_park_pkg::uid_t      in_uid,
  input  response_park_pkg::park_resp_t in_payload,
  output logic                         in_ready,
  input  logic                         full,
  // Allocate plane
  input  logic                         alloc_req,
  input  response_park_pkg::uid_t      alloc_uid,
  output logic                         alloc_gnt,
  output response_park_pkg::park_resp_t out_payload,
  // Free plane
  input  logic                         free_req,
  input  response_park_pkg::uid_t      free_uid,
  output logic                         free_ack,
  // Events for the occupancy tracker
  output logic                         enq_accept,
  output logic                         free_accept
);

  import response_park_pkg::*;

  // ----------------------------------------
  // Slot state
  // ----------------------------------------

  // Slot holds a parked response
  logic [`PARK_DEPTH-1:0] occupied_q;
  logic [`PARK_DEPTH-1:0] occupied_d;

  // Slot already granted, waiting for its free
  logic [`PARK_DEPTH-1:0] reserved_q;
  logic [`PARK_DEPTH-1:0] reserved_d;

  // Parked payloads, one per UID
  park_resp_t payload_mem [`PARK_DEPTH];

  // Allocate hits a parked, unclaimed slot
  logic alloc_hit;

  // ----------------------------------------
  // Request resolution
  // ----------------------------------------

  // No overwrite of a parked slot, no accept while full
  assign in_ready = ~full & ~occupied_q[in_uid];

  assign enq_accept = in_valid & in_ready;

  // Reserved slot gives no second grant
  assign alloc_hit = alloc_req & occupied_q[alloc_uid] & ~reserved_q[alloc_uid];

  // Free only counts for a slot that holds something
  assign free_accept = free_req & occupied_q[free_uid];

  // Next flags, applied in order enqueue, allocate, free
  // Enqueue and allocate never share a UID since their occupancy tests differ
  // Allocate plus free on one UID leaves the slot clear
  always_comb begin
    occupied_d = occupied_q;
    reserved_d = reserved_q;

    if (enq_accept) begin
      occupied_d[in_uid] = 1'b1;
      reserved_d[in_uid] = 1'b0;
    end

    if (alloc_hit) begin
      reserved_d[alloc_uid] = 1'b1;
    end

    if (free_accept) begin
      occupied_d[free_uid] = 1'b0;
      reserved_d[free_uid] = 1'b0;
    end
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  // Control flags and response pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      occupied_q <= '0;
      reserved_q <= '0;
      alloc_gnt  <= 1'b0;
      free_ack   <= 1'b0;
    end else begin
      occupied_q <= occupied_d;
      reserved_q <= reserved_d;
      // One-cycle pulses, one cycle after the request
      alloc_gnt  <= alloc_hit;
      free_ack   <= free_accept;
    end
  end

  // Capture the producer beat into its slot
  always_ff @(posedge clk) begin
    if (enq_accept) begin
      payload_mem[in_uid] <= in_payload;
    end
  end

  // Copy out on grant
  // Valid in the same cycle as alloc_gnt, consumer latches it there
  always_ff @(posedge clk) begin
    if (alloc_hit) begin
      out_payload <= payload_mem[alloc_uid];
    end
  end

  // ----------------------------------------
  // Assertions
  // ----------------------------------------

  // A just-filled UID reports not ready on the next cycle
  assert property (@(posedge clk) disable iff (rst)
    enq_accept |=> !(in_ready && (in_uid == $past(in_uid))))
    else $error("slot_table: in_ready high for occupied uid %0d", in_uid);

  // Reservation only ever sits on an occupied slot
  assert property (@(posedge clk) disable iff (rst)
    (reserved_q & ~occupied_q) == '0)
    else $error("slot_table: reserved slot not occupied, flags %h", reserved_q);

endmodule

// ==== sources.f ====
+incdir+source
source/response_park_pkg.sv
source/slot_table.sv
source/occupancy_tracker.sv
source/response_park.sv
tests/response_park_tb.sv

// ==== tests/response_park_tb.sv ====
// ----------------------------------------
// Testbench for the response park
// LFSR stimulus, slot model, port assertions
// ----------------------------------------

`timescale 1ns/1ps

`include "response_park_defines.svh"

module response_park_tb;

  import response_park_pkg::*;

  // Wide enough for any value that gets reported
  typedef logic [$bits(park_resp_t)-1:0] wide_t;

  localparam int wait_limit = 20;

  logic       clk;
  logic       rst;
  logic       in_valid;
  uid_t       in_uid;
  park_resp_t in_payload;
  logic       in_ready;
  logic       alloc_req;
  uid_t       alloc_uid;
  logic       alloc_gnt;
  park_resp_t out_payload;
  logic       free_req;
  uid_t       free_uid;
  logic       free_ack;
  logic       full;

  int value_errors = 0;
  int timeout_errors = 0;
  logic [31:0] lfsr_state;

  // ----------------------------------------
  // Clock and DUT
  // ----------------------------------------

  always #50 clk = ~clk;

  response_park u_response_park (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_uid      (in_uid),
    .in_payload  (in_payload),
    .in_ready    (in_ready),
    .alloc_req   (alloc_req),
    .alloc_uid   (alloc_uid),
    .alloc_gnt   (alloc_gnt),
    .out_payload (out_payload),
    .free_req    (free_req),
    .free_uid    (free_uid),
    .free_ack    (free_ack),
    .full        (full)
  );

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  logic [`PARK_DEPTH-1:0] m_occ;
  logic [`PARK_DEPTH-1:0] m_res;
  park_resp_t             m_payload [`PARK_DEPTH];
  count_t                 m_count;
  logic                   exp_gnt;
  logic                   exp_ack;
  park_resp_t             exp_payload;
  logic                   exp_full;
  logic                   exp_in_ready;

  // Leave-one-free threshold and no overwrite of a parked slot
  assign exp_full = (m_count == park_full_level);
  assign exp_in_ready = ~exp_full & ~m_occ[in_uid];

  always @(posedge clk) begin : model_update
    logic [`PARK_DEPTH-1:0] occ_n;
    logic [`PARK_DEPTH-1:0] res_n;
    logic enq;
    logic hit;
    logic fr;
    if (rst) begin
      m_occ   <= '0;
      m_res   <= '0;
      m_count <= '0;
      exp_gnt <= 1'b0;
      exp_ack <= 1'b0;
    end else begin
      enq = in_valid & exp_in_ready;
      // Grant only once per parked response
      hit = alloc_req & m_occ[alloc_uid] & ~m_res[alloc_uid];
      fr = free_req & m_occ[free_uid];
      occ_n = m_occ;
      res_n = m_res;
      if (enq) begin
        occ_n[in_uid] = 1'b1;
        res_n[in_uid] = 1'b0;
        m_payload[in_uid] <= in_payload;
      end
      if (hit) begin
        res_n[alloc_uid] = 1'b1;
        exp_payload <= m_payload[alloc_uid];
      end
      // Free after allocate, so both on one UID leaves it clear
      if (fr) begin
        occ_n[free_uid] = 1'b0;
        res_n[free_uid] = 1'b0;
      end
      m_occ   <= occ_n;
      m_res   <= res_n;
      exp_gnt <= hit;
      exp_ack <= fr;
      if (enq && !fr) begin
        m_count <= m_count + count_t'(1);
      end else if (fr && !enq) begin
        m_count <= m_count - count_t'(1);
      end
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  task automatic report_value(input string name, input wide_t exp, input wide_t act);
    value_errors++;
    $display("error: time %0t signal %s expected %h actual %h", $time, name, exp, act);
  endtask

  // Outputs idle and ready right after reset
  assert property (@(posedge clk) $fell(rst) |->
    (!alloc_gnt && !free_ack && !full && in_ready))
    else report_value("reset outputs {gnt,ack,full,ready}", wide_t'(4'b0001),
      wide_t'({$sampled(alloc_gnt), $sampled(free_ack), $sampled(full), $sampled(in_ready)}));

  assert property (@(posedge clk) disable iff (rst) alloc_gnt == exp_gnt)
    else report_value("alloc_gnt", wide_t'($sampled(exp_gnt)), wide_t'($sampled(alloc_gnt)));

  // Payload only means something in the grant cycle
  assert property (@(posedge clk) disable iff (rst) exp_gnt |-> out_payload == exp_payload)
    else report_value("out_payload", wide_t'($sampled(exp_payload)),
      wide_t'($sampled(out_payload)));

  assert property (@(posedge clk) disable iff (rst) free_ack == exp_ack)
    else report_value("free_ack", wide_t'($sampled(exp_ack)), wide_t'($sampled(free_ack)));

  assert property (@(posedge clk) disable iff (rst) full == exp_full)
    else report_value("full", wide_t'($sampled(exp_full)), wide_t'($sampled(full)));

  assert property (@(posedge clk) disable iff (rst) in_ready == exp_in_ready)
    else report_value("in_ready", wide_t'($sampled(exp_in_ready)), wide_t'($sampled(in_ready)));

  // ----------------------------------------
  // Random source
  // ----------------------------------------

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output wide_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[$bits(wide_t)-2:0], lfsr_state[0]};
    end
  endtask

  task automatic draw_uid(output uid_t u);
    wide_t v;
    draw_bits($bits(uid_t), v);
    u = uid_t'(v);
  endtask

  task automatic draw_payload(output park_resp_t p);
    wide_t v;
    draw_bits($bits(park_resp_t), v);
    p = park_resp_t'(v);
  endtask

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------

  // Hold one beat until the park takes it
  task automatic enqueue_beat(input uid_t uid, input park_resp_t payload);
    int cycles;
    @(posedge clk);
    in_valid   <= 1'b1;
    in_uid     <= uid;
    in_payload <= payload;
    cycles = 0;
    @(negedge clk);
    while (!in_ready && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!in_ready) begin
      timeout_errors++;
      $display("Timeout: enqueue to uid %0d was never accepted", uid);
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // Beat that the park must refuse for a few cycles
  task automatic offer_refused(input uid_t uid, input park_resp_t payload);
    @(posedge clk);
    in_valid   <= 1'b1;
    in_uid     <= uid;
    in_payload <= payload;
    repeat (3) @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic allocate_slot(input uid_t uid, input logic expect_gnt);
    int cycles;
    @(posedge clk);
    alloc_req <= 1'b1;
    alloc_uid <= uid;
    @(posedge clk);
    alloc_req <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (expect_gnt && !alloc_gnt && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (expect_gnt && !alloc_gnt) begin
      timeout_errors++;
      $display("Timeout: no grant for allocate of uid %0d", uid);
    end
  endtask

  task automatic free_slot(input uid_t uid, input logic expect_ack);
    int cycles;
    @(posedge clk);
    free_req <= 1'b1;
    free_uid <= uid;
    @(posedge clk);
    free_req <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (expect_ack && !free_ack && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (expect_ack && !free_ack) begin
      timeout_errors++;
      $display("Timeout: no acknowledge for free of uid %0d", uid);
    end
  endtask

  // Allocate and free one UID in the same cycle
  task automatic alloc_and_free(input uid_t uid);
    int cycles;
    @(posedge clk);
    alloc_req <= 1'b1;
    alloc_uid <= uid;
    free_req  <= 1'b1;
    free_uid  <= uid;
    @(posedge clk);
    alloc_req <= 1'b0;
    free_req  <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!(alloc_gnt && free_ack) && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!(alloc_gnt && free_ack)) begin
      timeout_errors++;
      $display("Timeout: joint allocate and free of uid %0d not answered", uid);
    end
  endtask

  // All three planes at random, same-cycle mixes included
  task automatic mixed_traffic(input int cycles);
    wide_t v;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      draw_bits(3, v);
      in_valid  <= v[0];
      alloc_req <= v[1];
      free_req  <= v[2];
      draw_bits($bits(uid_t), v);
      in_uid <= uid_t'(v);
      draw_bits($bits(uid_t), v);
      alloc_uid <= uid_t'(v);
      draw_bits($bits(uid_t), v);
      free_uid <= uid_t'(v);
      draw_bits($bits(park_resp_t), v);
      in_payload <= park_resp_t'(v);
    end
    @(posedge clk);
    in_valid  <= 1'b0;
    alloc_req <= 1'b0;
    free_req  <= 1'b0;
  endtask

  // Free every slot the model holds
  task automatic drain_all;
    @(negedge clk);
    for (int u = 0; u < `PARK_DEPTH; u++) begin
      if (m_occ[uid_t'(u)]) begin
        free_slot(uid_t'(u), 1'b1);
      end
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin : stimulus
    uid_t       uid;
    uid_t       skip;
    park_resp_t payload;
    clk        = 1'b0;
    lfsr_state = 32'h9727_c8b4;
    rst        <= 1'b1;
    in_valid   <= 1'b0;
    in_uid     <= '0;
    in_payload <= '0;
    alloc_req  <= 1'b0;
    alloc_uid  <= '0;
    free_req   <= 1'b0;
    free_uid   <= '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);

    // Park one response and hand it out
    draw_uid(uid);
    draw_payload(payload);
    enqueue_beat(uid, payload);
    allocate_slot(uid, 1'b1);

    // Already granted, then a slot with nothing parked
    allocate_slot(uid, 1'b0);
    allocate_slot(uid + uid_t'(1), 1'b0);

    // Occupied slot refuses until freed
    draw_payload(payload);
    offer_refused(uid, payload);
    free_slot(uid, 1'b1);
    enqueue_beat(uid, payload);
    alloc_and_free(uid);
    free_slot(uid, 1'b0);

    mixed_traffic(60);
    drain_all;

    // Fill to the headroom limit, one UID left empty
    draw_uid(skip);
    for (int u = 0; u < `PARK_DEPTH; u++) begin
      if (uid_t'(u) != skip) begin
        draw_payload(payload);
        enqueue_beat(uid_t'(u), payload);
      end
    end
    draw_payload(payload);
    offer_refused(skip, payload);
    free_slot(skip + uid_t'(1), 1'b1);
    // Empty now, so no ack and the count holds
    free_slot(skip + uid_t'(1), 1'b0);
    enqueue_beat(skip, payload);
    // Back at the limit
    offer_refused(skip + uid_t'(1), payload);
    drain_all;
    repeat (3) @(posedge clk);

    $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
